//--- dv/rgbScoreboard.sv
// ------------------------------
// Scoreboard on the memory port. Keeps a copy of the input image,
// builds the expected RGB words of a run from the filter and matrix
// rules, and compares every memory write in order.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module rgbScoreboard (
    input logic            Clock,
    input logic            Resetn,
    input busPkg::memReq_t memReq
);
    import busPkg::*;

    localparam int Half     = `LINE_PIXELS / 2;
    localparam int RunWords = 3 * Half * `FRAME_LINES;
    localparam int MemWords = `RGB_BASE + RunWords;

    memWord_t image [MemWords];
    memWord_t expected [$];
    int       runWrites = 0;
    int       checked = 0;
    int       errors = 0;

    task automatic storeWord(input int addr, input memWord_t word);
        image[addr] = word;
    endtask

    function automatic int limit255(input int value);
        return (value < 0) ? 0 : ((value > 255) ? 255 : value);
    endfunction

    // Symmetric taps, weight chosen by distance from the centre pair
    function automatic int tapWeight(input int t);
        case ((t < 5) ? 4 - t : t - 5)
            0:       return `FIR_C4;
            1:       return `FIR_C3;
            2:       return -`FIR_C2;
            3:       return -`FIR_C1;
            default: return `FIR_C0;
        endcase
    endfunction

    // Chroma sample s of a line, clamped to the line so edges repeat
    function automatic int chromaAt(input int base, input int line, input int s);
        int k;
        memWord_t w;
        k = (s < 0) ? 0 : ((s > Half - 1) ? Half - 1 : s);
        w = image[base + line * (Half / 2) + k / 2];
        return (k % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
    endfunction

    function automatic int oddSample(input int base, input int line, input int j);
        int acc;
        acc = `FIR_ROUND;
        for (int t = 0; t < `FIR_TAPS; t++) begin
            acc += tapWeight(t) * chromaAt(base, line, j - 4 + t);
        end
        return limit255(acc >>> `FIR_SHIFT);
    endfunction

    function automatic logic [7:0] channel(input int acc);
        return 8'(limit255((acc + `CSC_ROUND) >>> `CSC_SHIFT));
    endfunction

    function automatic logic [23:0] pixelRgb(input int yIn, input int uIn, input int vIn);
        int y;
        int u;
        int v;
        y = yIn - `Y_OFFSET;
        u = uIn - `C_OFFSET;
        v = vIn - `C_OFFSET;
        return {channel(`CSC_KY * y + `CSC_RV * v),
                channel(`CSC_KY * y - `CSC_GU * u - `CSC_GV * v),
                channel(`CSC_KY * y + `CSC_BU * u)};
    endfunction

    // Reference for one pixel pair, already in output word order
    function automatic logic [47:0] expectPair(input int line, input int j);
        memWord_t yWord;
        yWord = image[`Y_BASE + line * Half + j];
        return {pixelRgb(int'(yWord[15:8]), chromaAt(`U_BASE, line, j),
                         chromaAt(`V_BASE, line, j)),
                pixelRgb(int'(yWord[7:0]), oddSample(`U_BASE, line, j),
                         oddSample(`V_BASE, line, j))};
    endfunction

    task automatic expectRun();
        logic [47:0] words;
        expected.delete();
        runWrites = 0;
        for (int line = 0; line < `FRAME_LINES; line++) begin
            for (int j = 0; j < Half; j++) begin
                words = expectPair(line, j);
                expected.push_back(words[47:32]);
                expected.push_back(words[31:16]);
                expected.push_back(words[15:0]);
            end
        end
    endtask

    task automatic compareWrite(input memAddr_t addr, input memWord_t data);
        memWord_t want;
        int wantAddr;
        wantAddr = `RGB_BASE + runWrites;
        runWrites++;
        checked++;
        if (expected.size() == 0) begin
            errors++;
            $display("[ERROR] %0d ns: unexpected write of 0x%h at address %0d",
                     $time, data, addr);
        end else begin
            want = expected.pop_front();
            if (int'(addr) != wantAddr || data !== want) begin
                errors++;
                $display("[ERROR] %0d ns: wrote 0x%h at address %0d, expected 0x%h at %0d",
                         $time, data, addr, want, wantAddr);
            end
        end
    endtask

    task automatic finishRun();
        if (runWrites != RunWords || expected.size() != 0) begin
            errors++;
            $display("[ERROR] %0d ns: run wrote %0d words, expected %0d",
                     $time, runWrites, RunWords);
        end
    endtask

    // Write request is stable at the falling edge
    always @(negedge Clock) begin
        if (Resetn && memReq.writeEn) begin
            compareWrite(memReq.addr, memReq.wdata);
        end
    end

endmodule

`default_nettype wire

//--- dv/tbYuvToRgb.sv
// ------------------------------
// Testbench of the YUV to RGB converter. Drives the APB host port,
// models the external 16-bit memory and runs four frames back to
// back, then prints the closing report. Results are compared by
// the scoreboard instance on the memory port.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module tbYuvToRgb;
    import busPkg::*;

    localparam int Half        = `LINE_PIXELS / 2;
    localparam int MemWords    = `RGB_BASE + 3 * Half * `FRAME_LINES;
    localparam int IdleTimeout = 20 * `LINE_PIXELS * `FRAME_LINES + 200;

    // Frame contents
    localparam int RampFrame     = 0;
    localparam int RandomFrame   = 1;
    localparam int SaturateFrame = 2;
    localparam int EdgeFrame     = 3;

    logic     Clock;
    logic     Resetn;
    apbReq_t  apbReq;
    apbData_t prdata;
    memReq_t  memReq;
    memWord_t memRdata;

    memWord_t mem [MemWords];
    memReq_t  reqSeen;
    memWord_t readWord;
    int       seed = 58179;
    int       statusErrors = 0;
    int       timeouts = 0;

    yuvToRgb yuvToRgb_i (
        .Clock(Clock), .Resetn(Resetn), .apbReq(apbReq), .prdata(prdata),
        .memReq(memReq), .memRdata(memRdata)
    );

    rgbScoreboard scoreboard_i (.Clock(Clock), .Resetn(Resetn), .memReq(memReq));

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // Memory request is stable by the falling edge
    always @(negedge Clock) begin
        reqSeen = memReq;
    end

    // Synchronous memory whose read data follows the edge that took the address
    always @(posedge Clock) begin
        readWord = '0;
        if (int'(reqSeen.addr) < MemWords) begin
            if (reqSeen.writeEn) begin
                mem[int'(reqSeen.addr)] = reqSeen.wdata;
            end
            readWord = mem[int'(reqSeen.addr)];
        end
        #1 memRdata = readWord;
    end

    task automatic putWord(input int addr, input memWord_t word);
        mem[addr] = word;
        scoreboard_i.storeWord(addr, word);
    endtask

    function automatic logic [7:0] lumaSample(input int kind, input int line, input int p);
        case (kind)
            RampFrame:     return 8'(16 + 12 * p + 3 * line);
            RandomFrame:   return 8'($random(seed));
            SaturateFrame: return ((p + line) % 2 == 0) ? 8'd0 : 8'd255;
            default:       return 8'd128;
        endcase
    endfunction

    // Chroma sample s of a line with chan 0 for U and 1 for V
    function automatic logic [7:0] chromaSample(input int kind, input int line, input int s,
                                                input int chan);
        case (kind)
            RampFrame:     return 8'(40 + 20 * s + line + 10 * chan);
            RandomFrame:   return 8'($random(seed));
            SaturateFrame: return ((s + line + chan) % 2 == 0) ? 8'd0 : 8'd255;
            default: begin
                // Sharp steps at both line ends
                if (s == 0 || s == Half - 1) begin
                    return ((s == 0) ^ (chan == 1) ^ (line % 2 == 1)) ? 8'd255 : 8'd0;
                end
                return 8'd128;
            end
        endcase
    endfunction

    task automatic fillFrame(input int kind);
        for (int line = 0; line < `FRAME_LINES; line++) begin
            for (int k = 0; k < Half; k++) begin
                putWord(`Y_BASE + line * Half + k,
                        {lumaSample(kind, line, 2 * k), lumaSample(kind, line, 2 * k + 1)});
            end
            for (int k = 0; k < Half / 2; k++) begin
                putWord(`U_BASE + line * (Half / 2) + k,
                        {chromaSample(kind, line, 2 * k, 0),
                         chromaSample(kind, line, 2 * k + 1, 0)});
                putWord(`V_BASE + line * (Half / 2) + k,
                        {chromaSample(kind, line, 2 * k, 1),
                         chromaSample(kind, line, 2 * k + 1, 1)});
            end
        end
    endtask

    // Called one step after a rising edge and returns one step after one
    task automatic apbAccess(input logic write, input logic [3:0] addr,
                             input apbData_t wdata, output apbData_t rdata);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge Clock);
        #1;
        apbReq.penable = 1'b1;
        @(negedge Clock);
        rdata = prdata;
        @(posedge Clock);
        #1;
        apbReq = '0;
    endtask

    task automatic checkStatus(input logic [1:0] want);
        apbData_t value;
        apbAccess(1'b0, 4'd4, '0, value);
        if (value !== apbData_t'(want)) begin
            statusErrors++;
            $display("[ERROR] %0d ns: STATUS read 0x%h, expected 0x%h", $time, value, want);
        end
    endtask

    task automatic waitIdle();
        apbData_t value;
        int cycles;
        cycles = 0;
        value = 32'd1;
        while (value[0] && cycles < IdleTimeout) begin
            apbAccess(1'b0, 4'd4, '0, value);
            cycles += 2;
        end
        if (value[0]) begin
            timeouts++;
            $display("Timeout: busy still high after %0d cycles", cycles);
        end
    endtask

    task automatic runFrame(input int kind, input logic doneBefore);
        apbData_t unused;
        if (timeouts == 0) begin
            fillFrame(kind);
            scoreboard_i.expectRun();
            checkStatus({doneBefore, 1'b0});
            apbAccess(1'b1, 4'd0, 32'd1, unused);
            // Busy set and done cleared by the accepted start
            checkStatus(2'b01);
            apbAccess(1'b1, 4'd0, 32'd1, unused);
            waitIdle();
            if (timeouts == 0) begin
                checkStatus(2'b10);
                scoreboard_i.finishRun();
            end
        end
    endtask

    initial begin
        Resetn   = 1'b0;
        apbReq   = '0;
        memRdata = '0;
        reqSeen  = '0;
        for (int a = 0; a < MemWords; a++) begin
            mem[a] = memWord_t'(a ^ (a >> 16) ^ 'h5A5A);
        end
        repeat (2) @(posedge Clock);
        #1;
        Resetn = 1'b1;
        runFrame(RampFrame, 1'b0);
        runFrame(RandomFrame, 1'b1);
        runFrame(SaturateFrame, 1'b1);
        runFrame(EdgeFrame, 1'b1);
        // Idle tail where any late write shows up as unexpected
        repeat (8) @(posedge Clock);
        $display("Summary: %0d writes checked, %0d data errors, %0d status errors, %0d timeouts",
                 scoreboard_i.checked, scoreboard_i.errors, statusErrors, timeouts);
        if (scoreboard_i.errors + statusErrors + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/yuvToRgb_properties.sv
// ------------------------------
// Concurrent assertions on the memory port of the converter,
// bound into the top level.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module yuvToRgb_properties (
    input logic            Clock,
    input logic            Resetn,
    input logic            busy,
    input busPkg::memReq_t memReq
);
    import busPkg::*;

    localparam int RgbEnd = `RGB_BASE + 3 * (`LINE_PIXELS / 2) * `FRAME_LINES;

    memAddr_t lastAddr;
    logic     haveLast;

    // Address of the previous write in the current run
    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            haveLast <= 1'b0;
            lastAddr <= '0;
        end else if (!busy) begin
            haveLast <= 1'b0;
        end else if (memReq.writeEn) begin
            haveLast <= 1'b1;
            lastAddr <= memReq.addr;
        end
    end

    writeOnlyBusy: assert property (@(posedge Clock) disable iff (!Resetn)
        memReq.writeEn |-> busy)
        else $error("memory write while idle");

    writeInRgbRegion: assert property (@(posedge Clock) disable iff (!Resetn)
        memReq.writeEn |-> (int'(memReq.addr) >= `RGB_BASE && int'(memReq.addr) < RgbEnd))
        else $error("write address outside the RGB region");

    writeAddrStep: assert property (@(posedge Clock) disable iff (!Resetn)
        (memReq.writeEn && haveLast) |-> memReq.addr == lastAddr + 1'b1)
        else $error("write address does not follow the previous one");

endmodule

bind yuvToRgb yuvToRgb_properties properties_i (
    .Clock(Clock), .Resetn(Resetn), .busy(busy), .memReq(memReq)
);

`default_nettype wire

//--- include/yuvToRgb_macros.svh
// ------------------------------
// Geometry, memory map and arithmetic constants of the YUV 4:2:2 to
// RGB converter. Include wherever a constant or width is needed.
// LINE_PIXELS must be a multiple of 4 and at least 16.
// ------------------------------
`ifndef YUVTORGB_MACROS_SVH
`define YUVTORGB_MACROS_SVH

`define LINE_PIXELS 16
`define FRAME_LINES 4

// Word addresses of the four regions, packed back to back
`define Y_BASE      0
`define U_BASE      (`Y_BASE + (`LINE_PIXELS / 2) * `FRAME_LINES)
`define V_BASE      (`U_BASE + (`LINE_PIXELS / 4) * `FRAME_LINES)
`define RGB_BASE    (`V_BASE + (`LINE_PIXELS / 4) * `FRAME_LINES)

`define ADDR_W      18
`define DATA_W      16

// Interpolation filter, gain of 4096
`define FIR_TAPS    10
`define FIR_C0      36
`define FIR_C1      98
`define FIR_C2      233
`define FIR_C3      528
`define FIR_C4      1815
`define FIR_ROUND   2048
`define FIR_SHIFT   12

// Colour matrix, gain of 32768
`define CSC_KY      38142
`define CSC_RV      52298
`define CSC_GU      12845
`define CSC_GV      26640
`define CSC_BU      66093
`define CSC_ROUND   16384
`define CSC_SHIFT   15
`define Y_OFFSET    16
`define C_OFFSET    128

`endif

//--- list.f
+incdir+include
src/busPkg.sv
src/cscPkg.sv
src/apbControl.sv
src/lineSequencer.sv
src/chromaWindow.sv
src/chromaUpsampler.sv
src/colorConvert.sv
src/yuvToRgb.sv
dv/yuvToRgb_properties.sv
dv/rgbScoreboard.sv
dv/tbYuvToRgb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tbYuvToRgb -f list.f --Mdir obj_dir -o simYuvToRgb \
    && (./obj_dir/simYuvToRgb > sim.log 2>&1 || true)
grep -qx "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- src/apbControl.sv
// ------------------------------
// APB register block. CTRL at offset 0 starts a run,
// STATUS at offset 4 reports busy and sticky done.
// Zero wait states, never errors.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module apbControl (
    input  logic             Clock,
    input  logic             Resetn,
    input  busPkg::apbReq_t  apbReq,
    output busPkg::apbData_t prdata,
    input  logic             busy,
    input  logic             done,
    output logic             start
);
    import busPkg::*;

    logic access;

    assign access = apbReq.psel & apbReq.penable;

    // Start pulse one cycle after an accepted CTRL write
    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            start <= 1'b0;
        end else begin
            start <= access & apbReq.pwrite & (apbReq.paddr == 4'd0)
                & apbReq.pwdata[0] & ~busy;
        end
    end

    // CTRL reads back as zero
    always_comb begin
        prdata = '0;
        if (access && !apbReq.pwrite && apbReq.paddr == 4'd4) begin
            prdata = apbData_t'({done, busy});
        end
    end

endmodule

`default_nettype wire

//--- src/busPkg.sv
// ------------------------------
// Bus-domain types: APB request and data, and the request of the
// external 16-bit synchronous memory.
// ------------------------------
`default_nettype none

`include "yuvToRgb_macros.svh"

package busPkg;

    typedef logic [`ADDR_W-1:0] memAddr_t;
    typedef logic [`DATA_W-1:0] memWord_t;
    typedef logic [31:0]        apbData_t;

    typedef struct packed {
        memAddr_t addr;
        memWord_t wdata;
        logic     writeEn;
    } memReq_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [3:0] paddr;
        apbData_t   pwdata;
    } apbReq_t;

endpackage

`default_nettype wire

//--- src/chromaUpsampler.sv
// ------------------------------
// Ten-tap symmetric filter rebuilding odd-pixel U and V from the
// window. Output registered one cycle after the window.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module chromaUpsampler (
    input  logic                Clock,
    input  logic                Resetn,
    input  cscPkg::chromaWin_t  window,
    output cscPkg::chromaPair_t oddChroma
);
    import cscPkg::*;

    localparam int Coef [`FIR_TAPS] = '{
        `FIR_C0, -`FIR_C1, -`FIR_C2, `FIR_C3, `FIR_C4,
        `FIR_C4, `FIR_C3, -`FIR_C2, -`FIR_C1, `FIR_C0
    };

    int accU, accV;

    always_comb begin
        accU = `FIR_ROUND;
        accV = `FIR_ROUND;
        for (int t = 0; t < `FIR_TAPS; t++) begin
            accU += Coef[t] * int'(window[t].u);
            accV += Coef[t] * int'(window[t].v);
        end
    end

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            oddChroma <= '0;
        end else begin
            oddChroma.u <= clip8(accU >>> `FIR_SHIFT);
            oddChroma.v <= clip8(accV >>> `FIR_SHIFT);
        end
    end

endmodule

`default_nettype wire

//--- src/chromaWindow.sv
// ------------------------------
// Ten-deep window of U/V pairs feeding the interpolation filter.
// A load fills every tap with the first sample of the line, so the
// left edge is replicated; a shift appends one sample at the top.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module chromaWindow (
    input  logic                Clock,
    input  logic                Resetn,
    input  logic                winLoad,
    input  logic                winShift,
    input  cscPkg::chromaPair_t winSample,
    output cscPkg::chromaWin_t  window,
    output cscPkg::chromaPair_t winCentre
);
    import cscPkg::*;

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            window <= '0;
        end else if (winLoad) begin
            window <= {$bits(chromaWin_t)/$bits(chromaPair_t){winSample}};
        end else if (winShift) begin
            // Oldest tap drops out
            window <= {winSample, window[$high(window):1]};
        end
    end

    // Even pixel's own chroma
    assign winCentre = window[4];

endmodule

`default_nettype wire

//--- src/colorConvert.sv
// ------------------------------
// Fixed-point YUV to RGB matrix for one pixel pair, with rounding
// and clipping of every channel. Output registered one cycle later.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module colorConvert (
    input  logic             Clock,
    input  logic             Resetn,
    input  cscPkg::yuvPair_t yuv,
    output cscPkg::rgbPair_t rgb
);
    import cscPkg::*;

    function automatic sample_t scale(input int acc);
        return clip8((acc + `CSC_ROUND) >>> `CSC_SHIFT);
    endfunction

    function automatic rgbPixel_t toRgb(input sample_t yIn, input chromaPair_t c);
        int y;
        int u;
        int v;
        rgbPixel_t p;
        y = int'(yIn) - `Y_OFFSET;
        u = int'(c.u) - `C_OFFSET;
        v = int'(c.v) - `C_OFFSET;
        p.r = scale(`CSC_KY * y + `CSC_RV * v);
        p.g = scale(`CSC_KY * y - `CSC_GU * u - `CSC_GV * v);
        p.b = scale(`CSC_KY * y + `CSC_BU * u);
        return p;
    endfunction

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            rgb <= '0;
        end else begin
            rgb.even <= toRgb(yuv.yEven, yuv.cEven);
            rgb.odd  <= toRgb(yuv.yOdd, yuv.cOdd);
        end
    end

endmodule

`default_nettype wire

//--- src/cscPkg.sv
// ------------------------------
// Pixel-domain types shared by the chroma and colour datapath,
// plus the 8-bit clip used by both arithmetic stages.
// ------------------------------
`default_nettype none

`include "yuvToRgb_macros.svh"

package cscPkg;

    typedef logic [7:0] sample_t;

    typedef struct packed {
        sample_t u;
        sample_t v;
    } chromaPair_t;

    // Tap 0 is the oldest sample, tap FIR_TAPS-1 the newest
    typedef chromaPair_t [`FIR_TAPS-1:0] chromaWin_t;

    typedef struct packed {
        sample_t     yEven;
        sample_t     yOdd;
        chromaPair_t cEven;
        chromaPair_t cOdd;
    } yuvPair_t;

    typedef struct packed {
        sample_t r;
        sample_t g;
        sample_t b;
    } rgbPixel_t;

    typedef struct packed {
        rgbPixel_t even;
        rgbPixel_t odd;
    } rgbPair_t;

    // Saturate an already scaled result to 0..255
    function automatic sample_t clip8(input int value);
        if (value < 0) begin
            return 8'd0;
        end else if (value > 255) begin
            return 8'd255;
        end
        return sample_t'(value);
    endfunction

endpackage

`default_nettype wire

//--- src/lineSequencer.sv
// ------------------------------
// Frame and line FSM. Fills the chroma window at each line start,
// then runs six cycles per pixel pair: Y read, U and V reads every
// other pair, and three RGB writes. Drives the datapath inputs.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "yuvToRgb_macros.svh"

module lineSequencer (
    input  logic                Clock,
    input  logic                Resetn,
    input  logic                start,
    output logic                busy,
    output logic                done,
    output busPkg::memReq_t     memReq,
    input  busPkg::memWord_t    memRdata,
    output logic                winLoad,
    output logic                winShift,
    output cscPkg::chromaPair_t winSample,
    input  cscPkg::chromaPair_t winCentre,
    input  cscPkg::chromaPair_t oddChroma,
    output cscPkg::yuvPair_t    yuv,
    input  cscPkg::rgbPair_t    rgb
);
    import busPkg::*;
    import cscPkg::*;

    localparam int Half = `LINE_PIXELS / 2;

    typedef enum logic [3:0] {
        IDLE, LEAD_U, LEAD_V, LEAD_H, LEAD_A, LEAD_B,
        PAIR0, PAIR1, PAIR2, PAIR3, PAIR4, PAIR5
    } seqState_t;

    seqState_t   state;
    memAddr_t    yAddr, uAddr, vAddr, rgbAddr;
    logic [15:0] pairIdx, lineIdx;
    logic [1:0]  wordIdx;
    memWord_t    uBuf, vBuf;
    chromaPair_t lastSample;
    logic        fetch, repeatLast;

    // Next chroma word is read on odd pairs while the line has words left
    assign fetch      = pairIdx[0] && (int'(pairIdx) + 7 < Half);
    // Sample pairIdx+6 lies past the line end
    assign repeatLast = int'(pairIdx) + 6 >= Half;

    assign winLoad  = (state == LEAD_A) && (wordIdx == 2'd0);
    assign winShift = (state == LEAD_A && wordIdx != 2'd0) || state == LEAD_B
        || state == PAIR1;

    always_comb begin
        winSample = '{u: uBuf[15:8], v: vBuf[15:8]};
        if (state == LEAD_B || (state == PAIR1 && pairIdx[0])) begin
            winSample = '{u: uBuf[7:0], v: vBuf[7:0]};
        end
        if (state == PAIR1 && repeatLast) begin
            winSample = lastSample;
        end
    end

    always_comb begin
        memReq = '{addr: '0, wdata: '0, writeEn: 1'b0};
        case (state)
            LEAD_U: memReq.addr = uAddr;
            LEAD_V: memReq.addr = vAddr;
            PAIR0:  memReq.addr = yAddr;
            PAIR1:  memReq.addr = fetch ? uAddr : '0;
            PAIR2:  memReq.addr = fetch ? vAddr : '0;
            PAIR3:  memReq = '{addr: rgbAddr, wdata: {rgb.even.r, rgb.even.g}, writeEn: 1'b1};
            PAIR4:  memReq = '{addr: rgbAddr, wdata: {rgb.even.b, rgb.odd.r}, writeEn: 1'b1};
            PAIR5:  memReq = '{addr: rgbAddr, wdata: {rgb.odd.g, rgb.odd.b}, writeEn: 1'b1};
            default: memReq.addr = '0;
        endcase
    end

    // Payload registers
    always_ff @(posedge Clock) begin
        if (state == LEAD_V || (state == PAIR2 && fetch)) begin
            uBuf <= memRdata;
        end
        if (state == LEAD_H || (state == PAIR3 && fetch)) begin
            vBuf <= memRdata;
        end
        if (winLoad || winShift) begin
            lastSample <= winSample;
        end
        // Y word arrives here, window still holds this pair
        if (state == PAIR1) begin
            yuv <= '{yEven: memRdata[15:8], yOdd: memRdata[7:0],
                     cEven: winCentre, cOdd: oddChroma};
        end
    end

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            state   <= IDLE;
            busy    <= 1'b0;
            done    <= 1'b0;
            yAddr   <= '0;
            uAddr   <= '0;
            vAddr   <= '0;
            rgbAddr <= '0;
            pairIdx <= '0;
            lineIdx <= '0;
            wordIdx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        busy    <= 1'b1;
                        done    <= 1'b0;
                        yAddr   <= memAddr_t'(`Y_BASE);
                        uAddr   <= memAddr_t'(`U_BASE);
                        vAddr   <= memAddr_t'(`V_BASE);
                        rgbAddr <= memAddr_t'(`RGB_BASE);
                        lineIdx <= '0;
                        wordIdx <= '0;
                        state   <= LEAD_U;
                    end
                end
                LEAD_U: begin
                    uAddr <= uAddr + 1'b1;
                    state <= LEAD_V;
                end
                LEAD_V: begin
                    vAddr <= vAddr + 1'b1;
                    state <= LEAD_H;
                end
                LEAD_H: begin
                    // Fourth word stays buffered for the first two pairs
                    if (wordIdx == 2'd3) begin
                        pairIdx <= '0;
                        state   <= PAIR0;
                    end else begin
                        state <= LEAD_A;
                    end
                end
                LEAD_A: state <= LEAD_B;
                LEAD_B: begin
                    wordIdx <= wordIdx + 1'b1;
                    state   <= LEAD_U;
                end
                PAIR0: begin
                    yAddr <= yAddr + 1'b1;
                    state <= PAIR1;
                end
                PAIR1: begin
                    if (fetch) begin
                        uAddr <= uAddr + 1'b1;
                    end
                    state <= PAIR2;
                end
                PAIR2: begin
                    if (fetch) begin
                        vAddr <= vAddr + 1'b1;
                    end
                    state <= PAIR3;
                end
                PAIR3, PAIR4: begin
                    rgbAddr <= rgbAddr + 1'b1;
                    state   <= (state == PAIR3) ? PAIR4 : PAIR5;
                end
                PAIR5: begin
                    rgbAddr <= rgbAddr + 1'b1;
                    if (pairIdx != 16'(Half - 1)) begin
                        pairIdx <= pairIdx + 1'b1;
                        state   <= PAIR0;
                    end else if (lineIdx != 16'(`FRAME_LINES - 1)) begin
                        lineIdx <= lineIdx + 1'b1;
                        wordIdx <= '0;
                        state   <= LEAD_U;
                    end else begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/yuvToRgb.sv
// ------------------------------
// Top level of the YUV 4:2:2 to RGB frame converter.
// APB host port for control, single 16-bit memory port for data.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module yuvToRgb (
    input  logic             Clock,
    input  logic             Resetn,
    input  busPkg::apbReq_t  apbReq,
    output busPkg::apbData_t prdata,
    output busPkg::memReq_t  memReq,
    input  busPkg::memWord_t memRdata
);
    import cscPkg::*;

    logic        start, busy, done;
    logic        winLoad, winShift;
    chromaPair_t winSample, winCentre, oddChroma;
    chromaWin_t  window;
    yuvPair_t    yuv;
    rgbPair_t    rgb;

    apbControl apbControl_i (
        .Clock(Clock), .Resetn(Resetn), .apbReq(apbReq), .prdata(prdata),
        .busy(busy), .done(done), .start(start)
    );

    lineSequencer lineSequencer_i (
        .Clock(Clock), .Resetn(Resetn), .start(start), .busy(busy), .done(done),
        .memReq(memReq), .memRdata(memRdata),
        .winLoad(winLoad), .winShift(winShift), .winSample(winSample),
        .winCentre(winCentre), .oddChroma(oddChroma), .yuv(yuv), .rgb(rgb)
    );

    chromaWindow chromaWindow_i (
        .Clock(Clock), .Resetn(Resetn), .winLoad(winLoad), .winShift(winShift),
        .winSample(winSample), .window(window), .winCentre(winCentre)
    );

    chromaUpsampler chromaUpsampler_i (
        .Clock(Clock), .Resetn(Resetn), .window(window), .oddChroma(oddChroma)
    );

    colorConvert colorConvert_i (
        .Clock(Clock), .Resetn(Resetn), .yuv(yuv), .rgb(rgb)
    );

endmodule

`default_nettype wire
